// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the classifier testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_lenet_classifier \
    -f verilog.f \
    -Mdir obj_dir -o sim_lenet \
    || { echo "build failed"; exit 1; }

./obj_dir/sim_lenet 2>&1 | tee "$LOG"

# the log decides the result
[ -s "$LOG" ] || { echo "no simulation log"; exit 1; }
grep -qF '*** FAILED ***' "$LOG" && { echo "simulation failed"; exit 1; }
grep -qF '*** PASSED ***' "$LOG" || { echo "simulation ended without a result"; exit 1; }
exit 0

// ==== test/tb_lenet_classifier.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lenet_settings.svh"

module tb_lenet_classifier import lenet_pkg::*; ();

    localparam int CYCLE_LIMIT = 4000;  // roughly twice the load and vector phases

    logic      clk;
    logic      rst_n;
    logic      weight_we;
    digit_t    weight_neuron;
    term_idx_t weight_addr;
    pixel_t    weight_data;
    logic      start;
    logic      feature_valid;
    pixel_t    feature_in;
    digit_t    digit;
    logic      done;

    logic      last_tag;      // set with the FC_IN-th feature of a vector
    logic      last_strobe;
    logic      seen_start;
    integer    seed;
    int        cycle_count = 0;
    int        done_count  = 0;
    int        sent_count;

    // reference model copies of the weight stores, bias at index FC_IN
    int        w_model    [0:`FC_OUT-1][0:`FC_IN];
    int        feat_model [0:`FC_IN-1];

    // expected digits in send order
    digit_t     exp_digits [0:31];
    logic [4:0] exp_wr;
    logic [4:0] exp_rd = '0;
    logic [4:0] exp_count;
    digit_t     exp_head;

    assign exp_count   = exp_wr - exp_rd;
    assign exp_head    = exp_digits[exp_rd];
    assign last_strobe = feature_valid && last_tag;

    lenet_classifier DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .weight_we     (weight_we),
        .weight_neuron (weight_neuron),
        .weight_addr   (weight_addr),
        .weight_data   (weight_data),
        .start         (start),
        .feature_valid (feature_valid),
        .feature_in    (feature_in),
        .digit         (digit),
        .done          (done)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
            report_failure($sformatf("timeout after %0d cycles", cycle_count));
    end

    // one expected digit is consumed per done pulse
    always @(posedge clk) begin
        if (done) begin
            exp_rd     <= exp_rd + 5'd1;
            done_count <= done_count + 1;
        end
    end

    a_quiet_done: assert property (@(posedge clk) disable iff (!rst_n)
        !seen_start |-> !done)
        else report_failure($sformatf("done raised at %0t before any start", $time));

    a_quiet_digit: assert property (@(posedge clk) disable iff (!rst_n)
        !seen_start |-> (digit == '0))
        else report_failure($sformatf("mismatch at %0t: digit = %0d, expected 0",
                                      $time, $sampled(digit)));

    a_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> (exp_count != '0))
        else report_failure($sformatf("done pulse at %0t with no vector outstanding", $time));

    a_digit: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> (digit == exp_head))
        else report_failure($sformatf("mismatch at %0t: digit = %0d, expected %0d",
                                      $time, $sampled(digit), $sampled(exp_head)));

    a_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else report_failure($sformatf("done held high for more than one cycle at %0t", $time));

    // done two cycles after the edge that takes the last feature
    a_done_late: assert property (@(posedge clk) disable iff (!rst_n)
        $past(last_strobe, 3) |-> done)
        else report_failure($sformatf("done missing two cycles after last feature, %0t", $time));

    a_done_early: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> $past(last_strobe, 3))
        else report_failure($sformatf("done at %0t not tied to a last feature", $time));

    // bias plus dot product per neuron, lowest index wins a tie
    function automatic digit_t expected_digit();
        int best;
        int best_score;
        int s;
        best       = 0;
        best_score = 0;
        for (int n = 0; n < `FC_OUT; n++) begin
            s = w_model[n][`FC_IN];
            for (int k = 0; k < `FC_IN; k++) begin
                s += w_model[n][k] * feat_model[k];
            end
            if (n == 0 || s > best_score) begin
                best       = n;
                best_score = s;
            end
        end
        return digit_t'(best);
    endfunction

    task automatic drive_idle();
        @(posedge clk);
        start         <= 1'b0;
        feature_valid <= 1'b0;
        last_tag      <= 1'b0;
        weight_we     <= 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            drive_idle();
        end
    endtask

    task automatic write_weight(input int n, input int a, input int value);
        @(posedge clk);
        weight_we     <= 1'b1;
        weight_neuron <= digit_t'(n);
        weight_addr   <= term_idx_t'(a);
        weight_data   <= pixel_t'(value);
        w_model[n][a] = value;
    endtask

    task automatic load_random_weights();
        pixel_t v;
        for (int n = 0; n < `FC_OUT; n++) begin
            for (int a = 0; a <= `FC_IN; a++) begin
                v = pixel_t'($random(seed));
                write_weight(n, a, int'(v));
            end
        end
        drive_idle();
    endtask

    // feature strobes while the sequencer sits idle
    task automatic stray_strobes(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            start         <= 1'b0;
            feature_valid <= 1'b1;
            feature_in    <= pixel_t'($random(seed));
            last_tag      <= 1'b0;
            weight_we     <= 1'b0;
        end
    endtask

    task automatic send_vector(input int gap_max, input bit poke_weight, input bit poke_start);
        int     gap;
        pixel_t v;
        for (int k = 0; k < `FC_IN; k++) begin
            v = pixel_t'($random(seed));
            feat_model[k] = int'(v);
        end
        exp_digits[exp_wr] = expected_digit();
        exp_wr             = exp_wr + 5'd1;
        sent_count         = sent_count + 1;
        @(posedge clk);
        start         <= 1'b1;
        seen_start    <= 1'b1;
        feature_valid <= 1'b0;
        last_tag      <= 1'b0;
        weight_we     <= 1'b0;
        for (int k = 0; k < `FC_IN; k++) begin
            gap = (gap_max > 0) ? int'($unsigned($random(seed)) % (gap_max + 1)) : 0;
            for (int g = 0; g < gap; g++) begin
                drive_idle();
            end
            @(posedge clk);
            start         <= poke_start && (k == 20);   // ignored mid vector
            feature_valid <= 1'b1;
            feature_in    <= pixel_t'(feat_model[k]);
            last_tag      <= (k == `FC_IN - 1);
            weight_we     <= poke_weight && (k == 40);  // must be dropped
            weight_neuron <= digit_t'(2);
            weight_addr   <= term_idx_t'(`FC_IN);
            weight_data   <= pixel_t'(100);             // outbids the tied biases
        end
    endtask

    initial begin
        seed          = 27;
        rst_n         = 1'b0;
        weight_we     = 1'b0;
        weight_neuron = '0;
        weight_addr   = '0;
        weight_data   = '0;
        start         = 1'b0;
        feature_valid = 1'b0;
        feature_in    = '0;
        last_tag      = 1'b0;
        seen_start    = 1'b0;
        exp_wr        = '0;
        sent_count    = 0;
        for (int n = 0; n < `FC_OUT; n++) begin
            for (int a = 0; a <= `FC_IN; a++) begin
                w_model[n][a] = 0;
            end
        end
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        idle_cycles(10);            // outputs stay quiet before any start

        // weights still zero from reset, neurons 3 and 7 tie on the bias
        for (int n = 0; n < `FC_OUT; n++) begin
            write_weight(n, `FC_IN, (n == 3 || n == 7) ? 50 : n * 3 - 20);
        end
        drive_idle();
        // a bias write to neuron 2 mid vector would win if it landed
        send_vector(0, 1'b1, 1'b0);
        idle_cycles(6);

        load_random_weights();
        send_vector(0, 1'b0, 1'b0);
        idle_cycles(6);

        stray_strobes(4);
        send_vector(3, 1'b1, 1'b0);
        stray_strobes(3);
        idle_cycles(6);

        // back to back, next start one cycle after the last feature
        for (int i = 0; i < 8; i++) begin
            send_vector(0, 1'b0, 1'b0);
        end
        idle_cycles(6);

        send_vector(1, 1'b0, 1'b1);

        while (done_count < sent_count) begin
            drive_idle();
        end
        idle_cycles(10);
        if (done_count != sent_count) begin
            report_failure($sformatf("%0d done pulses for %0d vectors", done_count, sent_count));
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+verilog
verilog/lenet_pkg.sv
verilog/fc_sequencer.sv
verilog/fc_neuron.sv
verilog/argmax_unit.sv
verilog/lenet_classifier.sv
test/tb_lenet_classifier.sv

// ==== verilog/argmax_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lenet_settings.svh"

module argmax_unit import lenet_pkg::*; (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire acc_t scores [0:`FC_OUT-1],
    input  wire logic scores_valid,
    output digit_t    digit,
    output logic      done
);

    digit_t best_idx;
    acc_t   best_score;

    // scan in index order, strict compare keeps the lowest index on a tie
    always_comb begin
        best_idx   = '0;
        best_score = scores[0];
        for (int i = 1; i < `FC_OUT; i++) begin
            if (scores[i] > best_score) begin
                best_score = scores[i];
                best_idx   = digit_t'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            digit <= '0;
            done  <= 1'b0;
        end else begin
            done <= scores_valid;     // single cycle, scores_valid is a pulse
            if (scores_valid)
                digit <= best_idx;
        end
    end

    // the reported index always names a real neuron
    assert property (@(posedge clk) disable iff (!rst_n)
        done |-> (digit < digit_t'(`FC_OUT)))
        else $error("digit out of range at done");

endmodule

`default_nettype wire

// ==== verilog/fc_neuron.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lenet_settings.svh"

module fc_neuron import lenet_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire logic      we,
    input  wire term_idx_t wr_addr,
    input  wire pixel_t    wr_data,
    input  wire logic      term_valid,
    input  wire logic      term_first,
    input  wire term_idx_t term_idx,
    input  wire pixel_t    term_value,
    output acc_t           score
);

    // weights 0..FC_IN-1, bias at FC_IN
    pixel_t weights [0:`FC_IN];
    acc_t   acc;
    acc_t   product;
    acc_t   bias;

    assign product = weights[term_idx] * term_value;  // signed, sized to acc width
    assign bias    = acc_t'(weights[`FC_IN]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i <= `FC_IN; i++) begin
                weights[i] <= '0;
            end
        end else if (we && (wr_addr <= term_idx_t'(`FC_IN))) begin
            weights[wr_addr] <= wr_data;
        end
    end

    // multiply-accumulate, first term restarts from the bias
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
        end else if (term_valid) begin
            if (term_first)
                acc <= bias + product;
            else
                acc <= acc + product;
        end
    end

    assign score = acc;

    // writes only land while the sequencer is idle
    assert property (@(posedge clk) disable iff (!rst_n) !(we && term_valid))
        else $error("weight write collided with a term");

endmodule

`default_nettype wire

// ==== verilog/fc_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lenet_settings.svh"

module fc_sequencer import lenet_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              start,
    input  wire logic              feature_valid,
    input  wire pixel_t            feature_in,
    input  wire logic              weight_we,
    input  wire digit_t            weight_neuron,
    input  wire term_idx_t         weight_addr,
    input  wire pixel_t            weight_data,
    output logic [`FC_OUT-1:0]     neuron_we,
    output term_idx_t              wr_addr,
    output pixel_t                 wr_data,
    output logic                   term_valid,
    output logic                   term_first,
    output logic                   term_last,
    output term_idx_t              term_idx,
    output pixel_t                 term_value,
    output logic                   scores_valid
);

    seq_state_t state;
    term_idx_t  term_cnt;   // next feature position
    logic       accept;     // feature taken this cycle
    logic       cnt_last;

    assign accept   = feature_valid && (state == seq_accum);
    assign cnt_last = (term_cnt == term_idx_t'(`FC_IN - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= seq_idle;
            term_cnt <= '0;
        end else begin
            case (state)
                seq_idle: begin
                    if (start) begin
                        state    <= seq_accum;
                        term_cnt <= '0;
                    end
                end
                seq_accum: begin
                    // start pulses are ignored while a vector is in progress
                    if (accept) begin
                        term_cnt <= term_cnt + 1'b1;
                        if (cnt_last)
                            state <= seq_idle;
                    end
                end
                default: state <= seq_idle;
            endcase
        end
    end

    // term broadcast, one cycle behind the accepted feature
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            term_valid   <= 1'b0;
            term_first   <= 1'b0;
            term_last    <= 1'b0;
            scores_valid <= 1'b0;
        end else begin
            term_valid   <= accept;
            term_first   <= accept && (term_cnt == '0);
            term_last    <= accept && cnt_last;
            scores_valid <= term_valid && term_last;  // neurons just added the last term
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            term_idx   <= term_cnt;
            term_value <= feature_in;
        end
    end

    // weight writes are registered so they never overlap the trailing term
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            neuron_we <= '0;
        end else begin
            for (int i = 0; i < `FC_OUT; i++) begin
                neuron_we[i] <= weight_we && (state == seq_idle) &&
                                (weight_neuron == digit_t'(i));
            end
        end
    end

    always_ff @(posedge clk) begin
        wr_addr <= weight_addr;
        wr_data <= weight_data;
    end

    // stray strobes in idle must not leak into the neurons
    assert property (@(posedge clk) disable iff (!rst_n)
        (state == seq_idle) && feature_valid |=> !term_valid)
        else $error("term issued from a feature strobe in idle");

endmodule

`default_nettype wire

// ==== verilog/lenet_classifier.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lenet_settings.svh"

module lenet_classifier import lenet_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire logic      weight_we,
    input  wire digit_t    weight_neuron,
    input  wire term_idx_t weight_addr,
    input  wire pixel_t    weight_data,
    input  wire logic      start,
    input  wire logic      feature_valid,
    input  wire pixel_t    feature_in,
    output digit_t         digit,
    output logic           done
);

    logic [`FC_OUT-1:0] neuron_we;
    term_idx_t          wr_addr;
    pixel_t             wr_data;
    logic               term_valid;
    logic               term_first;
    term_idx_t          term_idx;
    pixel_t             term_value;
    logic               scores_valid;
    acc_t               scores [0:`FC_OUT-1];

    fc_sequencer u_sequencer (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .feature_valid (feature_valid),
        .feature_in    (feature_in),
        .weight_we     (weight_we),
        .weight_neuron (weight_neuron),
        .weight_addr   (weight_addr),
        .weight_data   (weight_data),
        .neuron_we     (neuron_we),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .term_valid    (term_valid),
        .term_first    (term_first),
        .term_last     (),            // only used inside the sequencer
        .term_idx      (term_idx),
        .term_value    (term_value),
        .scores_valid  (scores_valid)
    );

    // one neuron per digit, all fed by the same term broadcast
    for (genvar n = 0; n < `FC_OUT; n++) begin : g_neuron
        fc_neuron u_neuron (
            .clk        (clk),
            .rst_n      (rst_n),
            .we         (neuron_we[n]),
            .wr_addr    (wr_addr),
            .wr_data    (wr_data),
            .term_valid (term_valid),
            .term_first (term_first),
            .term_idx   (term_idx),
            .term_value (term_value),
            .score      (scores[n])
        );
    end

    argmax_unit u_argmax (
        .clk          (clk),
        .rst_n        (rst_n),
        .scores       (scores),
        .scores_valid (scores_valid),
        .digit        (digit),
        .done         (done)
    );

endmodule

`default_nettype wire

// ==== verilog/lenet_pkg.sv ====
`default_nettype none

`include "lenet_settings.svh"

package lenet_pkg;

    // signed feature value or weight
    typedef logic signed [`PIXEL_W-1:0] pixel_t;

    // neuron score, wide enough for the full dot product plus bias
    typedef logic signed [`ACC_W-1:0] acc_t;

    typedef logic [`DIGIT_W-1:0] digit_t;     // neuron / digit number
    typedef logic [`IDX_W-1:0]   term_idx_t;  // weight address inside a neuron

    // feature sequencer states
    typedef enum logic {
        seq_idle,
        seq_accum
    } seq_state_t;

endpackage

`default_nettype wire

// ==== verilog/lenet_settings.svh ====
`ifndef LENET_SETTINGS_SVH
`define LENET_SETTINGS_SVH

// classifier layer geometry
`define FC_IN    84   // features per vector, F6 outputs
`define FC_OUT   10   // digit neurons

// datapath widths
`define PIXEL_W  8    // feature and weight width
`define ACC_W    24   // holds 85 products of 8x8 bits

// bias sits at term index FC_IN, so the index needs one value more
`define IDX_W    7
`define DIGIT_W  4

`endif
